//--- hw/act_pkg.sv
// Shared widths and packed types for the activation stage.
// The configuration struct is quasi-static and may change only while both ports are idle.
`default_nettype none

package act_pkg;

  localparam int WI                   = 8;   // Activation width.
  localparam int GELU_CONSTANTS_WIDTH = 16;  // Width of one, b and c.
  localparam int GELU_OUT_WIDTH       = 32;  // Polynomial and product width.
  localparam int EMS                  = 8;   // Epsilon multiplier and shift width.

  // GELU constants and requantization settings, 96 bits in total.
  typedef struct packed {
    logic signed [GELU_CONSTANTS_WIDTH-1:0] one;      // Constant added to the erf term.
    logic signed [GELU_CONSTANTS_WIDTH-1:0] b;        // Polynomial offset, negative.
    logic signed [GELU_CONSTANTS_WIDTH-1:0] c;        // Polynomial constant.
    logic signed [EMS-1:0]                  eps_mult; // Requantization multiplier.
    logic        [EMS-1:0]                  right_shift; // Non-negative shift.
    logic        [GELU_OUT_WIDTH-1:0]       add;      // Output offset.
  } gelu_cfg_t;

  // One activation element with its end-of-row flag.
  typedef struct packed {
    logic signed [WI-1:0] data;
    logic                 last;
  } act_word_t;

endpackage

`default_nettype wire

//--- hw/act_ingress.sv
// Four-phase req/ack receiver in front of the activation FIFO.
// The source must hold in_word_i stable while in_req_i is high.
`timescale 1ns/1ps
`default_nettype none

module act_ingress
  import act_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      in_req_i,
  input  wire act_word_t in_word_i,
  output logic           in_ack_o,
  output logic           push_o,
  output act_word_t      push_word_o,
  input  wire logic      full_i
);

  logic ack_q;    // High from the push until the source releases req.
  logic push;

  // One push per handshake, held off while the FIFO is full.
  assign push = in_req_i && !ack_q && !full_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else if (push) begin
      ack_q <= 1'b1;           // Ack rises on the edge after the push.
    end else if (ack_q && !in_req_i) begin
      ack_q <= 1'b0;           // Release seen, ready for the next word.
    end
  end

  assign in_ack_o    = ack_q;
  assign push_o      = push;
  assign push_word_o = in_word_i;  // Word is stable during req.

endmodule

`default_nettype wire

//--- hw/act_fifo.sv
// Synchronous FIFO of activation words. FIFO_DEPTH must be a power of two, 2 or more.
// Push while full and pop while empty are ignored.
`timescale 1ns/1ps
`default_nettype none

module act_fifo
  import act_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      push_i,
  input  wire act_word_t push_word_i,
  output logic           full_o,
  input  wire logic      pop_i,
  output act_word_t      head_word_o,
  output logic           empty_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  act_word_t     mem_q [FIFO_DEPTH];  // Storage array.
  logic [AW:0]   wr_ptr_q;            // Extra bit tells full from empty.
  logic [AW:0]   rd_ptr_q;
  logic          do_push;
  logic          do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers are control state and are cleared by reset.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[AW-1:0]] <= push_word_i;
    end
  end

  assign head_word_o = mem_q[rd_ptr_q[AW-1:0]];  // Only meaningful when not empty.

endmodule

`default_nettype wire

//--- hw/gelu_core.sv
// Combinational integer GELU with requantization and saturation to signed 8 bits.
// Intermediate results wrap at GELU_OUT_WIDTH bits, as in the fixed-point model.
`timescale 1ns/1ps
`default_nettype none

module gelu_core
  import act_pkg::*;
(
  input  wire logic signed [WI-1:0] data_i,
  input  wire gelu_cfg_t            cfg_i,
  output logic signed [WI-1:0]      data_o
);

  localparam int GOW = GELU_OUT_WIDTH;
  localparam int PW  = GELU_OUT_WIDTH + EMS;  // Width after the epsilon multiply.

  localparam logic signed [WI-1:0] LOWER_BOUND = -(2**(WI-1)) + 1;
  localparam logic signed [WI-1:0] SAT_POS     = (2**(WI-1)) - 1;
  localparam logic signed [WI-1:0] SAT_NEG     = -(2**(WI-1));

  logic                  data_neg;
  logic signed [WI-1:0]  data_clip;
  logic signed [GOW-1:0] data_ext;
  logic signed [GOW-1:0] b_ext;
  logic signed [GOW-1:0] erf_abs;
  logic signed [GOW-1:0] erf_clip;
  logic signed [GOW-1:0] poly_d;
  logic signed [GOW-1:0] erf_l;
  logic signed [GOW-1:0] gelu_erf;
  logic signed [GOW-1:0] gelu_sum;
  logic signed [GOW-1:0] gelu_out;
  logic signed [PW-1:0]  product;
  logic signed [PW-1:0]  pre_round;
  logic signed [PW-1:0]  shifted;
  logic signed [PW-1:0]  shifted_added;
  logic        [PW-WI:0] upper;

  always_comb begin
    data_neg  = data_i[WI-1];
    data_clip = (data_i < LOWER_BOUND) ? LOWER_BOUND : data_i;  // Keep -x in range.
    data_ext  = GOW'(data_clip);
    b_ext     = GOW'(cfg_i.b);

    // Second-order erf estimate on the clipped magnitude.
    erf_abs  = data_neg ? -data_ext : data_ext;
    erf_clip = (erf_abs > -b_ext) ? -b_ext : erf_abs;
    poly_d   = erf_clip + b_ext;
    erf_l    = poly_d * poly_d + GOW'(cfg_i.c);

    gelu_erf = data_neg ? -erf_l : erf_l;
    gelu_sum = gelu_erf + GOW'(cfg_i.one);
    gelu_out = GOW'(data_i) * gelu_sum;

    // Requantize.
    product = PW'(gelu_out) * PW'(cfg_i.eps_mult);
    if (cfg_i.right_shift != '0) begin
      pre_round = product >>> (cfg_i.right_shift - 1'b1);  // Bit 0 is the last dropped bit.
      shifted   = pre_round >>> 1;
      if (pre_round[0]) begin
        shifted = shifted + 1;
      end
    end else begin
      pre_round = product;
      shifted   = product;
    end
    shifted_added = shifted + PW'(signed'(cfg_i.add));

    // Saturate when the bits above the result are not all sign copies.
    upper = shifted_added[PW-1:WI-1];
    if (upper == '0 || upper == '1) begin
      data_o = shifted_added[WI-1:0];
    end else if (shifted_added[PW-1]) begin
      data_o = SAT_NEG;
    end else begin
      data_o = SAT_POS;
    end
  end

endmodule

`default_nettype wire

//--- hw/gelu_egress.sv
// Pops the FIFO and offers each GELU result over a four-phase req/ack sender.
// The core reads cfg_i at the pop edge, so cfg_i must be stable then.
`timescale 1ns/1ps
`default_nettype none

module gelu_egress
  import act_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire gelu_cfg_t cfg_i,
  input  wire logic      empty_i,
  input  wire act_word_t head_word_i,
  output logic           pop_o,
  output logic           out_req_o,
  input  wire logic      out_ack_i,
  output act_word_t      out_word_o
);

  typedef enum logic [1:0] {
    ST_IDLE,     // No request, ack low.
    ST_REQ,      // Request held with a stable word.
    ST_RELEASE   // Ack seen, waiting for it to fall.
  } state_e;

  state_e               state_q;
  act_word_t            out_word_q;
  logic signed [WI-1:0] gelu_data;
  logic                 pop;

  gelu_core u_gelu_core (
    .data_i (head_word_i.data),
    .cfg_i  (cfg_i),
    .data_o (gelu_data)
  );

  assign pop = (state_q == ST_IDLE) && !empty_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      out_word_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop) begin
            out_word_q.data <= gelu_data;         // Captured at the pop edge.
            out_word_q.last <= head_word_i.last;
            state_q         <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (out_ack_i) begin
            state_q <= ST_RELEASE;                // Req drops here.
          end
        end
        ST_RELEASE: begin
          if (!out_ack_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign pop_o      = pop;
  assign out_req_o  = (state_q == ST_REQ);
  assign out_word_o = out_word_q;

endmodule

`default_nettype wire

//--- hw/gelu_act_top.sv
// Activation stage: four-phase ingress, word FIFO, GELU egress.
// cfg_i may change only while both handshake ports are idle.
`timescale 1ns/1ps
`default_nettype none

module gelu_act_top
  import act_pkg::*;
#(
  parameter int FIFO_DEPTH = 4   // Power of two, 2 or more.
) (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire gelu_cfg_t cfg_i,
  input  wire logic      in_req_i,
  input  wire act_word_t in_word_i,
  output logic           in_ack_o,
  output logic           out_req_o,
  input  wire logic      out_ack_i,
  output act_word_t      out_word_o
);

  logic      push;
  act_word_t push_word;
  logic      full;
  logic      pop;
  act_word_t head_word;
  logic      empty;

  act_ingress u_act_ingress (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_req_i    (in_req_i),
    .in_word_i   (in_word_i),
    .in_ack_o    (in_ack_o),
    .push_o      (push),
    .push_word_o (push_word),
    .full_i      (full)
  );

  act_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_act_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_word_i (push_word),
    .full_o      (full),
    .pop_i       (pop),
    .head_word_o (head_word),
    .empty_o     (empty)
  );

  gelu_egress u_gelu_egress (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_i       (cfg_i),
    .empty_i     (empty),
    .head_word_i (head_word),
    .pop_o       (pop),
    .out_req_o   (out_req_o),
    .out_ack_i   (out_ack_i),
    .out_word_o  (out_word_o)
  );

endmodule

`default_nettype wire

//--- tests/gelu_act_checker.sv
// Concurrent assertions on both req/ack ports and the FIFO, bound into gelu_act_top.
// Checks are disabled while rst_i is high.
`timescale 1ns/1ps
`default_nettype none

module gelu_act_checker
  import act_pkg::*;
(
  input wire logic      clk_i,
  input wire logic      rst_i,
  input wire logic      in_req_i,
  input wire logic      in_ack_i,
  input wire logic      out_req_i,
  input wire logic      out_ack_i,
  input wire act_word_t out_word_i,
  input wire logic      push_i,
  input wire logic      full_i,
  input wire logic      pop_i,
  input wire logic      empty_i
);

  int unsigned fail_count = 0;  // Number of assertion failures so far.

  req_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_req_i && !out_ack_i |=> out_req_i)
    else begin
      $error("out_req_o dropped before out_ack_i was seen");
      fail_count++;
    end

  word_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_req_i && !out_ack_i |=> $stable(out_word_i))
    else begin
      $error("out_word_o changed while out_req_o was high");
      fail_count++;
    end

  // Ack may only rise in answer to a request.
  ack_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !in_req_i && !in_ack_i |=> !in_ack_i)
    else begin
      $error("in_ack_o rose without in_req_i");
      fail_count++;
    end

  no_push_full_a: assert property (@(posedge clk_i) disable iff (rst_i)
    full_i |-> !push_i)
    else begin
      $error("FIFO push issued while full");
      fail_count++;
    end

  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (rst_i)
    empty_i |-> !pop_i)
    else begin
      $error("FIFO pop issued while empty");
      fail_count++;
    end

endmodule

bind gelu_act_top gelu_act_checker u_gelu_act_checker (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .in_req_i   (in_req_i),
  .in_ack_i   (in_ack_o),
  .out_req_i  (out_req_o),
  .out_ack_i  (out_ack_i),
  .out_word_i (out_word_o),
  .push_i     (push),
  .full_i     (full),
  .pop_i      (pop),
  .empty_i    (empty)
);

`default_nettype wire

//--- tests/gelu_act_tb.sv
// Testbench for gelu_act_top, stimulus and expected results from tests/gelu_stim.txt.
// Run from the project root. Test "burst" uses random ack delays, test "reset" resets mid-stream.
`timescale 1ns/1ps
`default_nettype none

module gelu_act_tb;
  import act_pkg::*;

  localparam int    FIFO_DEPTH = 4;
  localparam string STIM_FILE  = "tests/gelu_stim.txt";

  logic      clk_i;
  logic      rst_i;
  gelu_cfg_t cfg_i;
  logic      in_req_i;
  act_word_t in_word_i;
  logic      in_ack_o;
  logic      out_req_o;
  logic      out_ack_i;
  act_word_t out_word_o;

  string       stim_lines[$];
  act_word_t   pend_in[$];       // Words of the current test not yet sent.
  act_word_t   pend_exp[$];
  string       test_name = "";
  int          error_count = 0;
  int          errors_before = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_words = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;
  int          accepted = 0;     // Words acked by the ingress.
  int          delivered = 0;    // Words seen by the sink.
  int unsigned assert_failures = 0;

  gelu_act_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_gelu_act_top (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_i      (cfg_i),
    .in_req_i   (in_req_i),
    .in_word_i  (in_word_i),
    .in_ack_o   (in_ack_o),
    .out_req_o  (out_req_o),
    .out_ack_i  (out_ack_i),
    .out_word_o (out_word_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      error_count++;
    end
  endtask

  // Adds the bound assertions' new failures to the error count.
  task automatic collect_assertion_failures();
    int unsigned total;
    total = u_gelu_act_top.u_gelu_act_checker.fail_count;
    error_count += int'(total - assert_failures);
    assert_failures = total;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;                            // Drive and sample just after the edge.
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (4) next_cycle();
    rst_i = 1'b0;
  endtask

  task automatic send_word(input act_word_t word);
    in_word_i = word;
    in_req_i  = 1'b1;
    do begin
      next_cycle();
    end while (!in_ack_o);
    accepted++;
    if (accepted - delivered > FIFO_DEPTH + 1) begin
      $display("Ingress acked word %0d while the FIFO and output stage were full", accepted);
      error_count++;
    end
    in_req_i = 1'b0;
    do begin
      next_cycle();
    end while (in_ack_o);
  endtask

  task automatic receive_word(input act_word_t expected, input bit random_delay);
    int delay;
    delay = random_delay ? int'($urandom % 16) : 0;
    while (!out_req_o) begin
      next_cycle();
    end
    delivered++;
    check_value("out_word_o.data", $unsigned(expected.data), $unsigned(out_word_o.data));
    check_value("out_word_o.last", expected.last, out_word_o.last);
    repeat (delay) next_cycle();
    out_ack_i = 1'b1;
    do begin
      next_cycle();
    end while (out_req_o);
    out_ack_i = 1'b0;
  endtask

  task automatic run_words(input bit burst);
    if (burst) begin
      fork
        foreach (pend_in[i]) send_word(pend_in[i]);
        foreach (pend_exp[i]) receive_word(pend_exp[i], 1'b1);
      join
    end else begin
      foreach (pend_in[i]) begin
        fork
          send_word(pend_in[i]);
          receive_word(pend_exp[i], 1'b0);
        join
      end
    end
  endtask

  // Earlier words stay buffered and the last one is held acked across the reset.
  // Afterwards the last word must pass on its own.
  task automatic run_reset_test();
    act_word_t fresh_in;
    act_word_t fresh_exp;
    fresh_in  = pend_in.pop_back();
    fresh_exp = pend_exp.pop_back();
    foreach (pend_in[i]) send_word(pend_in[i]);
    in_word_i = fresh_in;          // Ack stays high into the reset.
    in_req_i  = 1'b1;
    do begin
      next_cycle();
    end while (!in_ack_o);
    apply_reset();
    in_req_i = 1'b0;
    if (in_ack_o !== 1'b0 || out_req_o !== 1'b0) begin
      $display("Handshake outputs were not idle after the mid-stream reset");
      error_count++;
    end
    check_value("out_word_o", '0, out_word_o);
    repeat (5) begin
      next_cycle();
      if (out_req_o) begin
        $display("A stale word was offered after the mid-stream reset");
        error_count++;
      end
    end
    fork
      send_word(fresh_in);
      receive_word(fresh_exp, 1'b0);
    join
  endtask

  task automatic flush_words();
    if (pend_in.size() == 0) return;
    accepted  = 0;
    delivered = 0;
    if (test_name == "reset") begin
      run_reset_test();
    end else begin
      run_words(test_name == "burst");
    end
    pend_in.delete();
    pend_exp.delete();
  endtask

  task automatic finish_test();
    int errs;
    flush_words();
    if (test_name.len() == 0) return;
    collect_assertion_failures();
    errs = error_count - errors_before;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %s finished: %0d words, %0d errors", test_name, test_words, errs);
    errors_before = error_count;
  endtask

  initial begin
    int            fd;
    int            n_data;
    string         line;
    string         tag;
    logic [31:0]   f_one, f_b, f_c, f_eps, f_shift, f_add;
    logic [31:0]   f_data, f_last, f_exp;
    act_word_t     word;
    void'($urandom(6931));
    rst_i      = 1'b1;
    cfg_i      = '0;
    in_req_i   = 1'b0;
    in_word_i  = '0;
    out_ack_i  = 1'b0;
    n_data     = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) stim_lines.push_back(line);
      end
      $fclose(fd);
    end
    foreach (stim_lines[i]) begin
      tag = "";
      if ($sscanf(stim_lines[i], "%s", tag) == 1 && tag == "D") n_data++;
    end
    cycle_limit = 40 * n_data + 100;

    apply_reset();
    foreach (stim_lines[i]) begin
      tag = "";
      void'($sscanf(stim_lines[i], "%s", tag));
      if (tag == "T") begin
        finish_test();
        void'($sscanf(stim_lines[i], "T %s", test_name));
        test_words = 0;
      end else if (tag == "C") begin
        flush_words();             // Both ports are idle from here.
        void'($sscanf(stim_lines[i], "C %h %h %h %h %h %h",
                      f_one, f_b, f_c, f_eps, f_shift, f_add));
        cfg_i.one         = f_one[GELU_CONSTANTS_WIDTH-1:0];
        cfg_i.b           = f_b[GELU_CONSTANTS_WIDTH-1:0];
        cfg_i.c           = f_c[GELU_CONSTANTS_WIDTH-1:0];
        cfg_i.eps_mult    = f_eps[EMS-1:0];
        cfg_i.right_shift = f_shift[EMS-1:0];
        cfg_i.add         = f_add;
      end else if (tag == "D") begin
        void'($sscanf(stim_lines[i], "D %h %h %h", f_data, f_last, f_exp));
        word.data = f_data[WI-1:0];
        word.last = f_last[0];
        pend_in.push_back(word);
        word.data = f_exp[WI-1:0];
        pend_exp.push_back(word);
        test_words++;
      end
    end
    finish_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gelu_act_top.f
hw/act_pkg.sv
hw/act_ingress.sv
hw/act_fifo.sv
hw/gelu_core.sv
hw/gelu_egress.sv
hw/gelu_act_top.sv
tests/gelu_act_checker.sv
tests/gelu_act_tb.sv

//--- tests/gelu_stim.txt
# T name | C one b c eps_mult right_shift add | D input last expected_output
# All numbers are hex. Expected outputs follow the integer GELU and requantization rule.
T single
C 0080 fff8 ffc0 03 06 00000000
D 00 0 00
D 01 0 05
D 05 0 11
D 14 0 3C
D 30 0 7F
D FF 0 F9
D F8 0 B8
D F0 1 80
T edges
C 0080 fff8 ffc0 01 01 00000000
D 80 0 80
D 81 0 80
D 00 0 00
D 7F 0 7F
D 01 0 39
D FF 0 B9
D 02 0 64
D 03 1 7F
T burst
C 0080 fff8 ffc0 03 06 00000000
D 0A 0 1E
D 14 0 3C
D 01 0 05
D FF 0 F9
D 02 0 09
D FD 0 E9
D F8 0 B8
D 05 1 11
T cfg_change
C 0040 fff0 0000 fe 04 00000005
D 00 0 05
D 01 0 E1
D FF 0 F1
D 04 0 9D
D 10 0 85
D 14 0 80
D F0 1 7F
T reset
D 04 0 9D
D 08 0 85
D 10 0 85
D 01 1 E1
